//--- llm_config.svh
/*
  Sizing for the page manager. LLM_NUM_PAGES must not exceed 2**LLM_PAGE_BITS.
  Packet lengths run from 1 to 2**LLM_LEN_BITS - 1 pages.
*/
`ifndef LLM_CONFIG_SVH
`define LLM_CONFIG_SVH

// width of a page number
`define LLM_PAGE_BITS 4

// pages in the buffer
`define LLM_NUM_PAGES 16

// width of a packet length in pages, zero is not a legal length
`define LLM_LEN_BITS 3

`endif

//--- llm_pkg.sv
/*
  Shared types for the page manager. Sizes come from llm_config.svh.
  The src field of a descriptor is filled in by the core, chainers leave it 0.
*/
`include "llm_config.svh"

package llm_pkg;

  typedef logic [`LLM_PAGE_BITS-1:0] page_t;

  // packet request from a source port
  typedef struct packed {
    logic [`LLM_LEN_BITS-1:0] len;
  } pkt_req_t;

  // one link memory write, last marks the stop page
  typedef struct packed {
    page_t page;
    page_t next;
    logic  last;
  } link_t;

  typedef struct packed {
    page_t                    head;
    logic [`LLM_LEN_BITS-1:0] len;
    logic                     src;
  } pkt_desc_t;

  // walk reply, next equals page on the stop page
  typedef struct packed {
    page_t page;
    page_t next;
    logic  last;
  } walk_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    REQ_PAGE,
    WAIT_PAGE,
    WRITE_LINK,
    SEND_HEAD
  } chain_state_e;

endpackage

//--- free_list.sv
/*
  Free page FIFO. Fills itself with pages 0..N-1 for N cycles after reset.
  pop_page is valid the cycle after a pop. No push or pop before init_done.
*/
`timescale 1ns/10ps
`include "llm_config.svh"

module free_list (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      push_valid,
  input  logic [`LLM_PAGE_BITS-1:0] push_page,
  input  logic                      pop_valid,
  output logic [`LLM_PAGE_BITS-1:0] pop_page,
  output logic                      empty,
  output logic [`LLM_PAGE_BITS:0]   count,
  output logic                      init_done
);

  localparam logic [`LLM_PAGE_BITS-1:0] LAST_SLOT = `LLM_PAGE_BITS'(`LLM_NUM_PAGES - 1);
  localparam logic [`LLM_PAGE_BITS:0]   FULL = (`LLM_PAGE_BITS + 1)'(`LLM_NUM_PAGES);

  logic [`LLM_PAGE_BITS-1:0] mem [`LLM_NUM_PAGES];
  logic [`LLM_PAGE_BITS-1:0] wr_ptr;
  logic [`LLM_PAGE_BITS-1:0] rd_ptr;
  logic [`LLM_PAGE_BITS-1:0] fill_page;
  logic                      wr_en;
  logic [`LLM_PAGE_BITS-1:0] wr_data;

  // fill counter owns the write port until init is done
  assign wr_en   = init_done ? push_valid : 1'b1;
  assign wr_data = init_done ? push_page : fill_page;
  assign empty   = (count == '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fill_page <= '0;
      init_done <= 1'b0;
      count     <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
    end
    else
    begin
      if (!init_done)
      begin
        fill_page <= fill_page + 1'b1;
        // count stays 0 while filling, then jumps to full
        if (fill_page == LAST_SLOT)
        begin
          init_done <= 1'b1;
          count     <= FULL;
        end
      end
      else
      begin
        case ({push_valid, pop_valid})
          2'b10: count <= count + 1'b1;
          2'b01: count <= count - 1'b1;
          default: count <= count;
        endcase
      end
      if (wr_en)
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      if (pop_valid)
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= wr_data;
    if (pop_valid)
      pop_page <= mem[rd_ptr];
  end

  // caller gates pops on empty, and a page is never freed twice
  assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid |-> init_done && !empty);
  assert property (@(posedge clk) disable iff (!rst_n)
    push_valid |-> init_done && (count != FULL));

endmodule

//--- page_chainer.sv
/*
  Builds one packet's page chain at a time, one page request outstanding.
  Links page n-1 to page n once page n arrives, then writes the stop link.
  Request length must be at least 1.
*/
`timescale 1ns/10ps
`include "llm_config.svh"

module page_chainer
  import llm_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req_valid,
  output logic      req_ready,
  input  pkt_req_t  req,
  output logic      alloc_valid,
  input  logic      alloc_ready,
  input  logic      page_valid,
  output logic      page_ready,
  input  page_t     page,
  output logic      link_valid,
  input  logic      link_ready,
  output link_t     link,
  output logic      head_valid,
  input  logic      head_ready,
  output pkt_desc_t head
);

  chain_state_e             state;
  logic [`LLM_LEN_BITS-1:0] len_r;
  logic [`LLM_LEN_BITS-1:0] got;
  page_t                    head_pg;
  page_t                    prev_pg;

  // handshakes straight from the state, so they hold until transfer
  assign req_ready   = (state == IDLE);
  assign alloc_valid = (state == REQ_PAGE);
  assign page_ready  = (state == WAIT_PAGE);
  assign link_valid  = (state == WRITE_LINK);
  assign head_valid  = (state == SEND_HEAD);
  assign head        = '{head: head_pg, len: len_r, src: 1'b0};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= IDLE;
      got   <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (req_valid)
          begin
            got   <= '0;
            state <= REQ_PAGE;
          end
        REQ_PAGE:
          if (alloc_ready)
            state <= WAIT_PAGE;
        WAIT_PAGE:
          if (page_valid)
          begin
            got <= got + 1'b1;
            // first page of a longer packet has nothing to link yet
            if (got == '0 && len_r != 1)
              state <= REQ_PAGE;
            else
              state <= WRITE_LINK;
          end
        WRITE_LINK:
          if (link_ready)
          begin
            if (link.last)
              state <= SEND_HEAD;
            else if (got != len_r)
              state <= REQ_PAGE;
          end
        SEND_HEAD:
          if (head_ready)
            state <= IDLE;
        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    case (state)
      IDLE:
        if (req_valid)
          len_r <= req.len;
      WAIT_PAGE:
        if (page_valid)
        begin
          prev_pg <= page;
          if (got == '0)
          begin
            head_pg <= page;
            link    <= '{page: page, next: page, last: 1'b1};
          end
          else
            link <= '{page: prev_pg, next: page, last: 1'b0};
        end
      WRITE_LINK:
        // all pages in, stop link goes out next
        if (link_ready && !link.last && got == len_r)
          link <= '{page: prev_pg, next: prev_pg, last: 1'b1};
      default: ;
    endcase
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid && req_ready) |-> (req.len != '0));

endmodule

//--- llm_core.sv
/*
  Shared free list and link memory for two chainers, round robin per channel.
  One page reply outstanding per port. Walked pages are freed on the rsp transfer,
  and only one walk is in flight at a time.
*/
`timescale 1ns/10ps
`include "llm_config.svh"

module llm_core
  import llm_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [1:0]              alloc_valid,
  output logic [1:0]              alloc_ready,
  output logic [1:0]              page_valid,
  input  logic [1:0]              page_ready,
  output page_t [1:0]             page,
  input  logic [1:0]              link_valid,
  output logic [1:0]              link_ready,
  input  link_t [1:0]             link,
  input  logic [1:0]              head_valid,
  output logic [1:0]              head_ready,
  input  pkt_desc_t [1:0]         head,
  output logic                    desc_valid,
  input  logic                    desc_ready,
  output pkt_desc_t               desc,
  input  logic                    walk_valid,
  output logic                    walk_ready,
  input  page_t                   walk_page,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output walk_rsp_t               rsp,
  output logic [`LLM_PAGE_BITS:0] free_count
);

  page_t       fl_pop_page;
  logic        fl_empty;
  logic        fl_init_done;
  logic        fl_pop;
  logic        fl_push;
  logic [1:0]  alloc_req;
  logic [1:0]  alloc_gnt;
  logic [1:0]  link_gnt;
  logic [1:0]  head_gnt;
  logic        alloc_rr;
  logic        link_rr;
  logic        desc_rr;
  logic [1:0]  page_fresh;
  page_t [1:0] page_hold;
  logic        desc_free;
  link_t       link_w;
  pkt_desc_t   desc_in;
  // next page and stop flag per page
  logic [`LLM_PAGE_BITS:0] link_mem [`LLM_NUM_PAGES];

  // prio 0 favours port 0 on a tie
  function automatic logic [1:0] rr_pick(input logic [1:0] req, input logic prio);
    logic [1:0] gnt;
    gnt = req;
    if (req == 2'b11)
      gnt = prio ? 2'b10 : 2'b01;
    return gnt;
  endfunction

  free_list free_list_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .push_valid(fl_push),
    .push_page (rsp.page),
    .pop_valid (fl_pop),
    .pop_page  (fl_pop_page),
    .empty     (fl_empty),
    .count     (free_count),
    .init_done (fl_init_done)
  );

  always_comb
  begin
    alloc_req = alloc_valid & ~page_valid;
    alloc_gnt = rr_pick(alloc_req, alloc_rr) & {2{fl_init_done && !fl_empty}};
    link_gnt  = rr_pick(link_valid, link_rr);
    desc_free = !desc_valid || desc_ready;
    head_gnt  = rr_pick(head_valid, desc_rr) & {2{desc_free}};
    link_w    = link_gnt[1] ? link[1] : link[0];
    desc_in     = head_gnt[1] ? head[1] : head[0];
    desc_in.src = head_gnt[1];
    // registered FIFO read lands the cycle after the grant
    for (int p = 0; p < 2; p++)
      page[p] = page_fresh[p] ? fl_pop_page : page_hold[p];
  end

  assign alloc_ready = alloc_gnt;
  assign link_ready  = link_gnt;
  assign head_ready  = head_gnt;
  assign fl_pop      = |alloc_gnt;
  assign walk_ready  = !rsp_valid;
  assign fl_push     = rsp_valid && rsp_ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      page_valid <= '0;
      page_fresh <= '0;
      alloc_rr   <= 1'b0;
      link_rr    <= 1'b0;
      desc_rr    <= 1'b0;
      desc_valid <= 1'b0;
      rsp_valid  <= 1'b0;
    end
    else
    begin
      page_fresh <= alloc_gnt;
      for (int p = 0; p < 2; p++)
      begin
        if (alloc_gnt[p])
          page_valid[p] <= 1'b1;
        else if (page_ready[p])
          page_valid[p] <= 1'b0;
      end
      // winner drops to low priority
      if (|alloc_gnt)
        alloc_rr <= alloc_gnt[0];
      if (|link_gnt)
        link_rr <= link_gnt[0];
      if (|head_gnt)
        desc_rr <= head_gnt[0];
      if (|head_gnt)
        desc_valid <= 1'b1;
      else if (desc_ready)
        desc_valid <= 1'b0;
      if (walk_valid && walk_ready)
        rsp_valid <= 1'b1;
      else if (rsp_ready)
        rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    for (int p = 0; p < 2; p++)
    begin
      if (page_fresh[p])
        page_hold[p] <= fl_pop_page;
    end
    if (|link_gnt)
      link_mem[link_w.page] <= {link_w.next, link_w.last};
    if (|head_gnt)
      desc <= desc_in;
    if (walk_valid && walk_ready)
    begin
      rsp.page              <= walk_page;
      {rsp.next, rsp.last}  <= link_mem[walk_page];
    end
  end

  // a free page only ever sits with one port
  assert property (@(posedge clk) disable iff (!rst_n)
    (page_valid[0] && page_valid[1]) |-> (page[0] != page[1]));

endmodule

//--- llm_top.sv
/*
  Two page chainers sharing one link list core.
  Descriptors carry the source port in src. Pages return to the free list
  only through the walk port.
*/
`timescale 1ns/10ps
`include "llm_config.svh"

module llm_top
  import llm_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [1:0]              req_valid,
  output logic [1:0]              req_ready,
  input  pkt_req_t [1:0]          req,
  output logic                    desc_valid,
  input  logic                    desc_ready,
  output pkt_desc_t               desc,
  input  logic                    walk_valid,
  output logic                    walk_ready,
  input  page_t                   walk_page,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output walk_rsp_t               rsp,
  output logic [`LLM_PAGE_BITS:0] free_count
);

  logic [1:0]      alloc_valid;
  logic [1:0]      alloc_ready;
  logic [1:0]      page_valid;
  logic [1:0]      page_ready;
  page_t [1:0]     page;
  logic [1:0]      link_valid;
  logic [1:0]      link_ready;
  link_t [1:0]     link;
  logic [1:0]      head_valid;
  logic [1:0]      head_ready;
  pkt_desc_t [1:0] head;

  for (genvar i = 0; i < 2; i++)
  begin : g_chain
    page_chainer page_chainer_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid[i]),
      .req_ready  (req_ready[i]),
      .req        (req[i]),
      .alloc_valid(alloc_valid[i]),
      .alloc_ready(alloc_ready[i]),
      .page_valid (page_valid[i]),
      .page_ready (page_ready[i]),
      .page       (page[i]),
      .link_valid (link_valid[i]),
      .link_ready (link_ready[i]),
      .link       (link[i]),
      .head_valid (head_valid[i]),
      .head_ready (head_ready[i]),
      .head       (head[i])
    );
  end

  llm_core llm_core_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .alloc_valid(alloc_valid),
    .alloc_ready(alloc_ready),
    .page_valid (page_valid),
    .page_ready (page_ready),
    .page       (page),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link       (link),
    .head_valid (head_valid),
    .head_ready (head_ready),
    .head       (head),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .desc       (desc),
    .walk_valid (walk_valid),
    .walk_ready (walk_ready),
    .walk_page  (walk_page),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .free_count (free_count)
  );

endmodule

//--- tb_llm.sv
/*
  Testbench for llm_top. Head pages are not predicted, every chain is walked.
  A page freed after a chain's descriptor arrived must not show up in that chain.
*/
`timescale 1ns/10ps
`include "llm_config.svh"

module tb_llm
  import llm_pkg::*;
();

  localparam logic [`LLM_PAGE_BITS:0] ALL_FREE = (`LLM_PAGE_BITS + 1)'(`LLM_NUM_PAGES);
  localparam int MAX_LEN = (1 << `LLM_LEN_BITS) - 1;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic [1:0]              req_valid = '0;
  logic [1:0]              req_ready;
  pkt_req_t [1:0]          req = '0;
  logic                    desc_valid;
  logic                    desc_ready = 1'b1;
  pkt_desc_t               desc;
  logic                    walk_valid = 1'b0;
  logic                    walk_ready;
  page_t                   walk_page = '0;
  logic                    rsp_valid;
  logic                    rsp_ready = 1'b1;
  walk_rsp_t               rsp;
  logic [`LLM_PAGE_BITS:0] free_count;

  // lengths still to drive, and lengths driven but not yet seen as descriptors
  logic [`LLM_LEN_BITS-1:0] pend_q [2][$];
  logic [`LLM_LEN_BITS-1:0] sent_q [2][$];
  pkt_desc_t walk_q [$];
  time       arrive_q [$];
  time       free_time [`LLM_NUM_PAGES];

  bit        hold_walks = 1'b0;
  bit        random_ready = 1'b0;
  bit        timed_out = 1'b0;
  bit        walking = 1'b0;
  pkt_desc_t cur_desc;
  time       cur_arrive;
  page_t     cur_page;
  int        walk_idx;
  int        total_reqs = 0;
  int        descs_seen = 0;
  int        chains_walked = 0;
  int        checks = 0;
  int        errors = 0;
  int        tests = 0;

  llm_top llm_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .desc_valid(desc_valid),
    .desc_ready(desc_ready),
    .desc      (desc),
    .walk_valid(walk_valid),
    .walk_ready(walk_ready),
    .walk_page (walk_page),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp),
    .free_count(free_count)
  );

  always #10 clk = ~clk;

  // a port's next descriptor belongs to its oldest outstanding request
  function automatic pkt_desc_t expect_desc(input logic src);
    pkt_desc_t exp;
    exp     = '0;
    exp.len = sent_q[src].pop_front();
    exp.src = src;
    return exp;
  endfunction

  function automatic logic [`LLM_LEN_BITS-1:0] rand_len();
    logic [31:0] r;
    r = $urandom_range(MAX_LEN, 1);
    return r[`LLM_LEN_BITS-1:0];
  endfunction

  task automatic check_desc(input pkt_desc_t got, input pkt_desc_t exp);
    checks++;
    if (got.len !== exp.len)
    begin
      errors++;
      $display("FAILED at %0t: desc.len got %0d expected %0d", $time, got.len, exp.len);
    end
    if (got.src !== exp.src)
    begin
      errors++;
      $display("FAILED at %0t: desc.src got %0d expected %0d", $time, got.src, exp.src);
    end
  endtask

  // next of an inner page is only known from the chain itself
  task automatic check_rsp(input walk_rsp_t got, input walk_rsp_t exp, input bit with_next);
    checks++;
    if (got.page !== exp.page)
    begin
      errors++;
      $display("FAILED at %0t: rsp.page got %0d expected %0d", $time, got.page, exp.page);
    end
    if (got.last !== exp.last)
    begin
      errors++;
      $display("FAILED at %0t: rsp.last got %0d expected %0d", $time, got.last, exp.last);
    end
    if (with_next && got.next !== exp.next)
    begin
      errors++;
      $display("FAILED at %0t: rsp.next got %0d expected %0d", $time, got.next, exp.next);
    end
  endtask

  task automatic check_count(input logic [`LLM_PAGE_BITS:0] got,
                             input logic [`LLM_PAGE_BITS:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED at %0t: free_count got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic queue_req(input int port, input logic [`LLM_LEN_BITS-1:0] len);
    pend_q[port].push_back(len);
    total_reqs++;
  endtask

  task automatic wait_free(input logic [`LLM_PAGE_BITS:0] target, input int limit);
    int n;
    n = 0;
    while (free_count != target && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (free_count != target)
    begin
      errors++;
      timed_out = 1'b1;
      $display("timeout at %0t: free_count stuck at %0d, waiting for %0d",
               $time, free_count, target);
    end
  endtask

  task automatic wait_walked(input int limit);
    int n;
    n = 0;
    while (chains_walked < total_reqs && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (chains_walked < total_reqs)
    begin
      errors++;
      timed_out = 1'b1;
      $display("timeout at %0t: only %0d of %0d chains walked",
               $time, chains_walked, total_reqs);
    end
  endtask

  task automatic report_test(input string name, input int first_err);
    tests++;
    if (errors == first_err)
      $display("test %0d %s: ok", tests, name);
    else
      $display("test %0d %s: %0d errors", tests, name, errors - first_err);
  endtask

  // request driver, one queue per port
  always @(posedge clk)
  begin
    logic [`LLM_LEN_BITS-1:0] nxt;
    if (rst_n)
    begin
      for (int p = 0; p < 2; p++)
      begin
        if (!req_valid[p] || req_ready[p])
        begin
          if (pend_q[p].size() > 0)
          begin
            nxt = pend_q[p].pop_front();
            req_valid[p]  <= 1'b1;
            req[p].len    <= nxt;
            sent_q[p].push_back(nxt);
          end
          else
            req_valid[p] <= 1'b0;
        end
      end
    end
  end

  // back-pressure on the two output channels
  always @(posedge clk)
  begin
    logic [31:0] r;
    r = $urandom();
    if (random_ready)
    begin
      desc_ready <= r[0];
      rsp_ready  <= r[1];
    end
    else
    begin
      desc_ready <= 1'b1;
      rsp_ready  <= 1'b1;
    end
  end

  // descriptor collector
  always @(posedge clk)
  begin
    logic port;
    if (rst_n && desc_valid && desc_ready)
    begin
      if (sent_q[0].size() == 0 && sent_q[1].size() == 0)
      begin
        errors++;
        $display("error at %0t: descriptor arrived with no request outstanding", $time);
      end
      else
      begin
        // a lone busy port is the only possible source
        if (sent_q[1].size() == 0)
          port = 1'b0;
        else if (sent_q[0].size() == 0)
          port = 1'b1;
        else
          port = desc.src;
        check_desc(desc, expect_desc(port));
      end
      walk_q.push_back(desc);
      arrive_q.push_back($time);
      descs_seen++;
    end
  end

  // chain walker, one page in flight
  always @(posedge clk)
  begin
    walk_rsp_t exp_rsp;
    if (rst_n)
    begin
      if (walk_valid && walk_ready)
        walk_valid <= 1'b0;
      if (rsp_valid && rsp_ready)
      begin
        if (!walking)
        begin
          errors++;
          $display("error at %0t: walk reply with no walk outstanding", $time);
        end
        else
        begin
          exp_rsp.page = cur_page;
          exp_rsp.last = (walk_idx == int'(cur_desc.len) - 1);
          exp_rsp.next = cur_page;
          check_rsp(rsp, exp_rsp, exp_rsp.last);
          if (free_time[rsp.page] >= cur_arrive)
          begin
            errors++;
            $display("error at %0t: page %0d of chain with head %0d also sat in another chain",
                     $time, rsp.page, cur_desc.head);
          end
          free_time[rsp.page] = $time;
          if (rsp.last || exp_rsp.last)
          begin
            walking = 1'b0;
            chains_walked++;
          end
          else
          begin
            walk_idx++;
            cur_page = rsp.next;
            walk_valid <= 1'b1;
            walk_page  <= rsp.next;
          end
        end
      end
      if (!walking && !hold_walks && walk_q.size() > 0)
      begin
        cur_desc   = walk_q.pop_front();
        cur_arrive = arrive_q.pop_front();
        cur_page   = cur_desc.head;
        walk_idx   = 0;
        walking    = 1'b1;
        walk_valid <= 1'b1;
        walk_page  <= cur_desc.head;
      end
    end
  end

  initial
  begin
    int first_err;
    void'($urandom(32'h344a_f5c8));
    rst_n = 1'b0;
    for (int i = 0; i < `LLM_NUM_PAGES; i++)
      free_time[i] = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // fill takes one cycle per page, count jumps to full on the last one
    first_err = errors;
    repeat (`LLM_NUM_PAGES - 1) @(posedge clk);
    @(negedge clk);
    check_count(free_count, '0);
    @(negedge clk);
    check_count(free_count, ALL_FREE);
    report_test("free list fill", first_err);

    if (!timed_out)
    begin
      first_err = errors;
      @(negedge clk);
      queue_req(0, `LLM_LEN_BITS'(5));
      wait_walked(2000);
      report_test("single chain on port 0", first_err);
    end

    if (!timed_out)
    begin
      first_err = errors;
      @(negedge clk);
      for (int n = 0; n < 8; n++)
      begin
        queue_req(0, rand_len());
        queue_req(1, rand_len());
      end
      wait_walked(20000);
      report_test("random lengths on both ports", first_err);
    end

    // 29 pages asked for, the list runs dry until walks resume
    if (!timed_out)
    begin
      first_err = errors;
      @(negedge clk);
      hold_walks = 1'b1;
      queue_req(0, `LLM_LEN_BITS'(7));
      queue_req(1, `LLM_LEN_BITS'(7));
      queue_req(0, `LLM_LEN_BITS'(6));
      queue_req(1, `LLM_LEN_BITS'(4));
      queue_req(0, `LLM_LEN_BITS'(5));
      wait_free('0, 2000);
      repeat (40) @(posedge clk);
      if (descs_seen >= total_reqs)
      begin
        errors++;
        $display("error at %0t: all requests finished although walks were held", $time);
      end
      @(negedge clk);
      hold_walks = 1'b0;
      wait_walked(20000);
      report_test("stall on empty free list", first_err);
    end

    if (!timed_out)
    begin
      first_err = errors;
      @(negedge clk);
      random_ready = 1'b1;
      for (int n = 0; n < 8; n++)
      begin
        queue_req(0, rand_len());
        queue_req(1, rand_len());
      end
      wait_walked(40000);
      @(negedge clk);
      random_ready = 1'b0;
      report_test("random back-pressure", first_err);
    end

    // the last walk frees its page on the same edge it is counted
    if (!timed_out)
    begin
      first_err = errors;
      @(negedge clk);
      check_count(free_count, ALL_FREE);
      if (walk_q.size() != 0 || sent_q[0].size() != 0 || sent_q[1].size() != 0)
      begin
        errors++;
        $display("error at %0t: requests or descriptors left over at the end", $time);
      end
      report_test("all pages returned", first_err);
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- list.f
+incdir+.
llm_pkg.sv
free_list.sv
page_chainer.sv
llm_core.sv
llm_top.sv
tb_llm.sv

//--- Makefile
TOP = tb_llm

all: run

build:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
